// File: hdl/spi_slave_pkg.sv
// spi slave shared types
`default_nettype none

package spi_slave_pkg;

   //############################################################
   // data and address types
   //############################################################

   typedef logic [7:0] byte_t;       // register byte, spi data byte
   typedef logic [5:0] reg_addr_t;   // low six bits of the command byte

   //############################################################
   // command opcode, top two bits of the command byte
   //############################################################

   typedef enum logic [1:0] {
      op_write  = 2'b00,             // next byte goes into a register
      op_unused = 2'b01,             // rest of the selection ignored
      op_read   = 2'b10,             // next byte shifts a register out
      op_remote = 2'b11              // next PW bits form a core packet
   } spi_op_e;

   // decode fsm states
   typedef enum logic [2:0] {
      st_idle   = 3'd0,              // deselected or between commands
      st_cmd    = 3'd1,              // collecting the command byte
      st_read   = 3'd2,              // shifting register out on miso
      st_write  = 3'd3,              // collecting the write byte
      st_remote = 3'd4,              // collecting the remote packet
      st_ignore = 3'd5               // unused opcode, wait for deselect
   } spi_state_e;

   // decode to register file
   typedef struct packed {
      logic      wr;                 // one-cycle write strobe
      reg_addr_t addr;               // target register
      byte_t     data;               // byte to write
   } reg_access_t;

   // bit in the packet control byte, set for a remote write
   localparam int unsigned CTRL_WRITE_BIT = 0;

endpackage

`default_nettype wire

// File: hdl/spi_pin_sync.sv
// spi pin synchronizer
`timescale 1ns/100ps
`default_nettype none

module spi_pin_sync
  (
   input  logic clk,
   input  logic ss,          // async system reset
   input  logic sclk,        // raw spi clock pin
   input  logic csn,         // raw select, active low
   input  logic mosi,        // raw data in
   output logic sclk_rise,   // one-cycle pulse per sclk rising edge
   output logic sclk_fall,   // one-cycle pulse per sclk falling edge
   output logic selected,    // csn low, synchronized
   output logic mosi_s       // mosi aligned with sclk_rise
  );

   logic [1:0] sclk_sync;    // two-flop synchronizers
   logic [1:0] csn_sync;
   logic [1:0] mosi_sync;
   logic       sclk_d;       // delayed sclk for edge detect

   //############################################################
   // two-flop synchronizers
   //############################################################

   always_ff @(posedge clk or posedge ss)
   begin
      if (ss)
      begin
         sclk_sync <= 2'b00;
         csn_sync  <= 2'b11;                    // deselected out of reset
         mosi_sync <= 2'b00;
      end
      else
      begin
         sclk_sync <= {sclk_sync[0], sclk};
         csn_sync  <= {csn_sync[0], csn};
         mosi_sync <= {mosi_sync[0], mosi};
      end
   end

   //############################################################
   // edge flop, third stage
   //############################################################

   always_ff @(posedge clk or posedge ss)
   begin
      if (ss)
      begin
         sclk_d    <= 1'b0;
         sclk_rise <= 1'b0;
         sclk_fall <= 1'b0;
         selected  <= 1'b0;
         mosi_s    <= 1'b0;
      end
      else
      begin
         sclk_d    <= sclk_sync[1];
         sclk_rise <= sclk_sync[1] & ~sclk_d & ~csn_sync[1];  // no edges when deselected
         sclk_fall <= ~sclk_sync[1] & sclk_d & ~csn_sync[1];
         selected  <= ~csn_sync[1];
         mosi_s    <= mosi_sync[1];                          // same depth as the strobes
      end
   end

endmodule

`default_nettype wire

// File: hdl/spi_cmd_decode.sv
// spi command decode
`timescale 1ns/100ps
`default_nettype none

module spi_cmd_decode
  #(
   parameter  int AW = 16,            // core address width
   localparam int PW = 2*AW+40        // remote packet width
  )
  (
   input  logic                       clk,
   input  logic                       ss,
   input  logic                       sclk_rise,
   input  logic                       sclk_fall,
   input  logic                       selected,
   input  logic                       mosi_s,
   output spi_slave_pkg::reg_access_t reg_wr,       // write port of the regfile
   output spi_slave_pkg::reg_addr_t   rd_addr,      // combinational read address
   input  spi_slave_pkg::byte_t       rd_data,
   output logic                       miso,
   output logic                       packet_done,  // one-cycle pulse
   output logic [PW-1:0]              rx_packet     // valid with packet_done
  );

   localparam int unsigned CMD_END  = 8;            // command byte complete
   localparam int unsigned BYTE_END = 16;           // data byte complete
   localparam int unsigned PKT_END  = 8 + PW;       // remote packet complete

   spi_slave_pkg::spi_state_e state;
   spi_slave_pkg::spi_state_e state_nxt;
   spi_slave_pkg::spi_op_e    op;                   // opcode of the command byte
   spi_slave_pkg::reg_addr_t  addr_q;               // held for the write
   spi_slave_pkg::byte_t      tx_shift;             // miso shift register
   logic [PW-1:0]             rx_shift;             // mosi shift register
   logic [7:0]                bit_count;            // bits since command start
   logic                      cmd_done;
   logic                      write_done;
   logic                      read_done;

   //############################################################
   // receive path
   //############################################################

   // msb first, no reset on payload
   always_ff @(posedge clk)
   begin
      if (sclk_rise)
         rx_shift <= {rx_shift[PW-2:0], mosi_s};
   end

   always_ff @(posedge clk or posedge ss)
   begin
      if (ss)
         bit_count <= '0;
      else if (!selected || write_done || read_done || packet_done)
         bit_count <= '0;                           // restart for the next command
      else if (sclk_rise)
         bit_count <= bit_count + 8'd1;
   end

   assign op = spi_slave_pkg::spi_op_e'(rx_shift[7:6]);

   // all checked in the cycle after the strobe that completed them
   assign cmd_done    = (state == spi_slave_pkg::st_cmd)    && (bit_count == 8'(CMD_END));
   assign write_done  = (state == spi_slave_pkg::st_write)  && (bit_count == 8'(BYTE_END));
   assign read_done   = (state == spi_slave_pkg::st_read)   && (bit_count == 8'(BYTE_END));
   assign packet_done = (state == spi_slave_pkg::st_remote) && (bit_count == 8'(PKT_END));

   //############################################################
   // transaction fsm
   //############################################################

   always_comb
   begin
      state_nxt = state;
      case (state)
         spi_slave_pkg::st_idle:
            if (selected)
               state_nxt = spi_slave_pkg::st_cmd;
         spi_slave_pkg::st_cmd:
            if (cmd_done)
            begin
               case (op)
                  spi_slave_pkg::op_write:  state_nxt = spi_slave_pkg::st_write;
                  spi_slave_pkg::op_read:   state_nxt = spi_slave_pkg::st_read;
                  spi_slave_pkg::op_remote: state_nxt = spi_slave_pkg::st_remote;
                  default:                  state_nxt = spi_slave_pkg::st_ignore;
               endcase
            end
         spi_slave_pkg::st_read:
            if (read_done)
               state_nxt = spi_slave_pkg::st_idle;
         spi_slave_pkg::st_write:
            if (write_done)
               state_nxt = spi_slave_pkg::st_idle;
         spi_slave_pkg::st_remote:
            if (packet_done)
               state_nxt = spi_slave_pkg::st_idle;
         spi_slave_pkg::st_ignore:
            state_nxt = spi_slave_pkg::st_ignore;   // only deselect gets out
         default:
            state_nxt = spi_slave_pkg::st_idle;
      endcase
      if (!selected)
         state_nxt = spi_slave_pkg::st_idle;        // deselect aborts anything
   end

   always_ff @(posedge clk or posedge ss)
   begin
      if (ss)
         state <= spi_slave_pkg::st_idle;
      else
         state <= state_nxt;
   end

   // write address from the command byte
   always_ff @(posedge clk)
   begin
      if (cmd_done)
         addr_q <= rx_shift[5:0];
   end

   //############################################################
   // transmit path
   //############################################################

   // first fall after the load is skipped, master samples bit 7 first
   always_ff @(posedge clk or posedge ss)
   begin
      if (ss)
         tx_shift <= '0;
      else if (!selected)
         tx_shift <= '0;                            // quiet miso between selections
      else if (cmd_done && op == spi_slave_pkg::op_read)
         tx_shift <= rd_data;
      else if (sclk_fall && state == spi_slave_pkg::st_read &&
               bit_count != 8'(CMD_END))
         tx_shift <= {tx_shift[6:0], 1'b0};
   end

   assign miso = tx_shift[7];

   //############################################################
   // outputs
   //############################################################

   assign rd_addr   = rx_shift[5:0];                // valid while cmd_done
   assign reg_wr    = '{wr: write_done, addr: addr_q, data: rx_shift[7:0]};
   assign rx_packet = rx_shift;

endmodule

`default_nettype wire

// File: hdl/spi_regfile.sv
// spi register file
`timescale 1ns/100ps
`default_nettype none

module spi_regfile
  #(
   parameter int SREGS = 16                  // byte registers, 16 to 64
  )
  (
   input  logic                                   clk,
   input  logic                                   ss,
   input  spi_slave_pkg::reg_access_t             reg_wr,   // strobe, address, data
   input  spi_slave_pkg::reg_addr_t               rd_addr,
   output spi_slave_pkg::byte_t                   rd_data,  // combinational
   output spi_slave_pkg::byte_t [SREGS-1:0]       regs      // configuration to the core
  );

   spi_slave_pkg::byte_t [SREGS-1:0] regs_q;
   logic                             wr_hit;     // write inside the array
   logic                             rd_hit;     // read inside the array

   //############################################################
   // address range
   //############################################################

   // addresses at or above SREGS do not exist
   assign wr_hit = reg_wr.wr && (int'(reg_wr.addr) < SREGS);
   assign rd_hit = int'(rd_addr) < SREGS;

   //############################################################
   // storage
   //############################################################

   always_ff @(posedge clk or posedge ss)
   begin
      if (ss)
         regs_q <= '0;                           // all registers clear
      else if (wr_hit)
         regs_q[reg_wr.addr] <= reg_wr.data;
   end

   //############################################################
   // read port
   //############################################################

   always_comb
   begin
      rd_data = '0;                              // missing registers read 0
      if (rd_hit)
         rd_data = regs_q[rd_addr];
   end

   // whole array straight out
   assign regs = regs_q;

endmodule

`default_nettype wire

// File: hdl/spi_core_access.sv
// spi remote core access
`timescale 1ns/100ps
`default_nettype none

module spi_core_access
  #(
   parameter  int AW = 16,               // core address width
   localparam int PW = 2*AW+40           // remote packet width
  )
  (
   input  logic          clk,
   input  logic          ss,
   input  logic          packet_done,    // pulse from decode
   input  logic [PW-1:0] rx_packet,      // valid with packet_done
   output logic          access_out,     // one-cycle core access strobe
   output logic [PW-1:0] packet_out,     // held until the next packet
   output logic          read_request    // access is a remote read
  );

   logic [PW-1:0]        packet_q;
   spi_slave_pkg::byte_t ctrl;           // control byte, top of the packet

   assign ctrl = rx_packet[PW-1 -: 8];

   //############################################################
   // packet capture
   //############################################################

   always_ff @(posedge clk)
   begin
      if (packet_done)
         packet_q <= rx_packet;
   end

   assign packet_out = packet_q;

   //############################################################
   // strobes
   //############################################################

   // both line up with the new packet_out
   always_ff @(posedge clk or posedge ss)
   begin
      if (ss)
      begin
         access_out   <= 1'b0;
         read_request <= 1'b0;
      end
      else
      begin
         access_out   <= packet_done;
         read_request <= packet_done & ~ctrl[spi_slave_pkg::CTRL_WRITE_BIT];  // clear bit is a read
      end
   end

endmodule

`default_nettype wire

// File: hdl/spi_slave_top.sv
// spi slave top level
`timescale 1ns/100ps
`default_nettype none

module spi_slave_top
  #(
   parameter  int SREGS = 16,                    // register count
   parameter  int AW    = 16,                    // core address width
   localparam int PW    = 2*AW+40                // remote packet width
  )
  (
   input  logic                              clk,          // core clock, > 4x sclk
   input  logic                              ss,           // async system reset
   input  logic                              sclk,
   input  logic                              csn,
   input  logic                              mosi,
   output logic                              miso,
   output logic                              access_out,
   output logic [PW-1:0]                     packet_out,
   output logic                              read_request,
   output spi_slave_pkg::byte_t [SREGS-1:0]  regs
  );

   //############################################################
   // internal wires
   //############################################################

   logic                       sclk_rise;
   logic                       sclk_fall;
   logic                       selected;
   logic                       mosi_s;
   spi_slave_pkg::reg_access_t reg_wr;
   spi_slave_pkg::reg_addr_t   rd_addr;
   spi_slave_pkg::byte_t       rd_data;
   logic                       packet_done;
   logic [PW-1:0]              rx_packet;

   // pins into clk
   spi_pin_sync u_spi_pin_sync
     (.clk(clk), .ss(ss), .sclk(sclk), .csn(csn), .mosi(mosi),
      .sclk_rise(sclk_rise), .sclk_fall(sclk_fall), .selected(selected),
      .mosi_s(mosi_s));

   // command decode and shift registers
   spi_cmd_decode #(.AW(AW)) u_spi_cmd_decode
     (.clk(clk), .ss(ss), .sclk_rise(sclk_rise), .sclk_fall(sclk_fall),
      .selected(selected), .mosi_s(mosi_s), .reg_wr(reg_wr), .rd_addr(rd_addr),
      .rd_data(rd_data), .miso(miso), .packet_done(packet_done),
      .rx_packet(rx_packet));

   // configuration registers
   spi_regfile #(.SREGS(SREGS)) u_spi_regfile
     (.clk(clk), .ss(ss), .reg_wr(reg_wr), .rd_addr(rd_addr),
      .rd_data(rd_data), .regs(regs));

   // remote packets to the core
   spi_core_access #(.AW(AW)) u_spi_core_access
     (.clk(clk), .ss(ss), .packet_done(packet_done), .rx_packet(rx_packet),
      .access_out(access_out), .packet_out(packet_out),
      .read_request(read_request));

endmodule

`default_nettype wire

// File: testbench/spi_slave_properties.sv
// decode fsm properties
`timescale 1ns/100ps
`default_nettype none

module spi_slave_properties
  (
   input logic                       clk,
   input logic                       ss,
   input spi_slave_pkg::spi_state_e  state,
   input logic                       packet_done,
   input spi_slave_pkg::reg_access_t reg_wr
  );

   int unsigned fail_count = 0;      // failed properties so far

   //############################################################
   // pulse and strobe rules
   //############################################################

   // packet_done lasts a single cycle
   packet_done_pulse: assert property (@(posedge clk) disable iff (ss)
                                       packet_done |=> !packet_done)
      else
      begin
         $error("packet_done held high for more than one cycle");
         fail_count = fail_count + 1;
      end

   // write strobe follows a cycle in st_write, fsm idle right after it
   wr_in_write_state: assert property (@(posedge clk) disable iff (ss)
                                       $rose(reg_wr.wr) |->
                                          $past(state) == spi_slave_pkg::st_write
                                          ##1 state == spi_slave_pkg::st_idle)
      else
      begin
         $error("register write strobe not framed by st_write and st_idle");
         fail_count = fail_count + 1;
      end

   //############################################################
   // reset
   //############################################################

   idle_after_reset: assert property (@(posedge clk)
                                      $fell(ss) |-> state == spi_slave_pkg::st_idle)
      else
      begin
         $error("decode fsm not in st_idle when reset released");
         fail_count = fail_count + 1;
      end

endmodule

bind spi_cmd_decode spi_slave_properties u_spi_slave_properties
  (.clk(clk), .ss(ss), .state(state), .packet_done(packet_done), .reg_wr(reg_wr));

`default_nettype wire

// File: testbench/spi_slave_tb.sv
// spi slave testbench
`timescale 1ns/100ps
`default_nettype none

module spi_slave_tb;

   localparam int SREGS     = 16;                  // dut defaults
   localparam int AW        = 16;
   localparam int PW        = 2*AW+40;             // remote packet width
   localparam int N_ENTRIES = 16;
   localparam int HALF_SCLK = 8;                   // clk cycles per sclk phase
   localparam int TIMEOUT   = N_ENTRIES * (PW+16) * 16 + 200;

   typedef enum logic [2:0] {k_write, k_read, k_remote, k_unused, k_abort} kind_e;

   // one row of the stimulus table
   typedef struct packed {
      kind_e                    kind;
      spi_slave_pkg::reg_addr_t addr;
      logic [PW-1:0]            payload;           // data byte in the low bits
      spi_slave_pkg::byte_t     expect_rd;         // read entries only
   } entry_t;

   logic                             clk;
   logic                             ss;
   logic                             sclk;
   logic                             csn;
   logic                             mosi;
   logic                             miso;
   logic                             access_out;
   logic [PW-1:0]                    packet_out;
   logic                             read_request;
   spi_slave_pkg::byte_t [SREGS-1:0] regs;

   entry_t                           table_q [N_ENTRIES];
   spi_slave_pkg::byte_t [SREGS-1:0] reg_model;    // only completed writes
   int unsigned                      cycle_count    = 0;
   int unsigned                      access_count   = 0;
   int unsigned                      read_req_count = 0;
   logic [PW-1:0]                    last_packet    = '0;

   spi_slave_top u_spi_slave_top
     (.clk(clk), .ss(ss), .sclk(sclk), .csn(csn), .mosi(mosi), .miso(miso),
      .access_out(access_out), .packet_out(packet_out),
      .read_request(read_request), .regs(regs));

   //############################################################
   // clock, monitor, timeout
   //############################################################

   initial clk = 1'b0;
   always #5 clk = ~clk;                           // 10 ns

   // count core strobes, keep the packet seen with access_out
   always @(posedge clk)
   begin
      if (access_out)
      begin
         access_count = access_count + 1;
         last_packet  = packet_out;
      end
      if (read_request)
         read_req_count = read_req_count + 1;
   end

   always @(posedge clk)
   begin
      cycle_count = cycle_count + 1;
      if (cycle_count > TIMEOUT)
      begin
         $display("timeout: table not finished after %0d clk cycles", cycle_count);
         $display("Testbench failed");
         $fatal(1, "run stopped by the cycle limit");
      end
   end

   //############################################################
   // helpers
   //############################################################

   task automatic stop_on_mismatch(input string msg);
      $display("CHECK FAILED at %0t: %s", $time, msg);
      $display("Testbench failed");
      $fatal(1, "stopped at first mismatch");
   endtask

   function automatic entry_t make_entry(input kind_e kind,
                                         input spi_slave_pkg::reg_addr_t addr,
                                         input logic [PW-1:0] payload,
                                         input spi_slave_pkg::byte_t expect_rd);
      entry_t e;
      e.kind      = kind;
      e.addr      = addr;
      e.payload   = payload;
      e.expect_rd = expect_rd;
      return e;
   endfunction

   // one sclk period, mosi set while low, miso taken at the rise
   task automatic shift_bit(input logic b, output logic sampled);
      mosi = b;
      repeat (HALF_SCLK) @(negedge clk);
      sclk    = 1'b1;
      sampled = miso;
      repeat (HALF_SCLK) @(negedge clk);
      sclk = 1'b0;
   endtask

   task automatic shift_byte(input spi_slave_pkg::byte_t tx, output spi_slave_pkg::byte_t rx);
      logic b;
      for (int i = 7; i >= 0; i--)
      begin
         shift_bit(tx[i], b);
         rx[i] = b;                                // msb first
      end
   endtask

   task automatic select_begin;
      csn = 1'b0;
      repeat (HALF_SCLK) @(negedge clk);           // selected through the sync
   endtask

   task automatic select_end;
      repeat (HALF_SCLK) @(negedge clk);
      csn  = 1'b1;
      mosi = 1'b0;
      repeat (HALF_SCLK) @(negedge clk);           // decode back to idle
   endtask

   //############################################################
   // stimulus table
   //############################################################

   task automatic build_table;
      logic [95:0]   rnd;
      logic [PW-1:0] pkt_wr;                       // ctrl byte marks a write
      logic [PW-1:0] pkt_rd;                       // ctrl byte marks a read
      rnd    = {$urandom, $urandom, $urandom};
      pkt_wr = rnd[PW-1:0];
      pkt_wr[PW-8+spi_slave_pkg::CTRL_WRITE_BIT] = 1'b1;
      rnd    = {$urandom, $urandom, $urandom};
      pkt_rd = rnd[PW-1:0];
      pkt_rd[PW-8+spi_slave_pkg::CTRL_WRITE_BIT] = 1'b0;
      table_q[0]  = make_entry(k_read,   6'h03, '0,         8'h00);  // reset value
      table_q[1]  = make_entry(k_read,   6'h0f, '0,         8'h00);
      table_q[2]  = make_entry(k_write,  6'h05, PW'(8'ha5), 8'h00);
      table_q[3]  = make_entry(k_read,   6'h05, '0,         8'ha5);
      table_q[4]  = make_entry(k_write,  6'h00, PW'(8'h3c), 8'h00);
      table_q[5]  = make_entry(k_read,   6'h00, '0,         8'h3c);
      table_q[6]  = make_entry(k_write,  6'h20, PW'(8'h77), 8'h00);  // beyond SREGS
      table_q[7]  = make_entry(k_read,   6'h20, '0,         8'h00);
      table_q[8]  = make_entry(k_remote, 6'h00, pkt_wr,     8'h00);
      table_q[9]  = make_entry(k_remote, 6'h01, pkt_rd,     8'h00);
      table_q[10] = make_entry(k_abort,  6'h05, PW'(8'h5a), 8'h00);  // half a byte
      table_q[11] = make_entry(k_read,   6'h05, '0,         8'ha5);
      table_q[12] = make_entry(k_unused, 6'h05, PW'(8'hff), 8'h00);
      table_q[13] = make_entry(k_write,  6'h0f, PW'(8'hc3), 8'h00);
      table_q[14] = make_entry(k_read,   6'h0f, '0,         8'hc3);
      table_q[15] = make_entry(k_read,   6'h3f, '0,         8'h00);
   endtask

   task automatic run_entry(input entry_t e);
      spi_slave_pkg::byte_t rx;
      spi_slave_pkg::byte_t model_rd;
      logic                 b;
      int unsigned          acc_before;
      int unsigned          rdq_before;
      int unsigned          exp_acc;
      int unsigned          exp_rdq;
      acc_before = access_count;
      rdq_before = read_req_count;
      exp_acc    = (e.kind == k_remote) ? 1 : 0;
      exp_rdq    = 0;
      select_begin();
      case (e.kind)
         k_write:
         begin
            shift_byte({2'b00, e.addr}, rx);
            shift_byte(e.payload[7:0], rx);
            if (int'(e.addr) < SREGS)
               reg_model[e.addr] = e.payload[7:0];
         end
         k_read:
         begin
            shift_byte({2'b10, e.addr}, rx);
            shift_byte(8'h00, rx);                 // miso byte comes back here
            model_rd = (int'(e.addr) < SREGS) ? reg_model[e.addr] : 8'h00;
            assert (rx == e.expect_rd)
               else stop_on_mismatch($sformatf("read %02h got %02h, table says %02h",
                                               e.addr, rx, e.expect_rd));
            assert (rx == model_rd)
               else stop_on_mismatch($sformatf("read %02h got %02h, model says %02h",
                                               e.addr, rx, model_rd));
         end
         k_remote:
         begin
            shift_byte({2'b11, e.addr}, rx);
            for (int i = PW-1; i >= 0; i--)
               shift_bit(e.payload[i], b);
            exp_rdq = e.payload[PW-8+spi_slave_pkg::CTRL_WRITE_BIT] ? 0 : 1;
         end
         k_unused:
         begin
            shift_byte({2'b01, e.addr}, rx);
            shift_byte(e.payload[7:0], rx);
         end
         default:
         begin
            shift_byte({2'b00, e.addr}, rx);       // abort after 4 data bits
            for (int i = 7; i >= 4; i--)
               shift_bit(e.payload[i], b);
         end
      endcase
      select_end();
      assert (access_count - acc_before == exp_acc)
         else stop_on_mismatch($sformatf("access_out pulsed %0d times, expected %0d",
                                         access_count - acc_before, exp_acc));
      assert (read_req_count - rdq_before == exp_rdq)
         else stop_on_mismatch($sformatf("read_request pulsed %0d times, expected %0d",
                                         read_req_count - rdq_before, exp_rdq));
      if (e.kind == k_remote)
         assert (last_packet == e.payload)
            else stop_on_mismatch($sformatf("packet_out %h, sent %h", last_packet, e.payload));
      assert (regs == reg_model)
         else stop_on_mismatch($sformatf("regs %h differ from model %h", regs, reg_model));
   endtask

   //############################################################
   // main sequence
   //############################################################

   initial
   begin
      void'($urandom(45500));
      ss        = 1'b1;
      sclk      = 1'b0;
      csn       = 1'b1;
      mosi      = 1'b0;
      reg_model = '0;
      build_table();
      repeat (4) @(negedge clk);
      ss = 1'b0;
      repeat (4) @(negedge clk);
      assert (regs == '0 && miso == 1'b0 && access_out == 1'b0 && read_request == 1'b0)
         else stop_on_mismatch("outputs or registers not clear after reset");
      for (int n = 0; n < N_ENTRIES; n++)
         run_entry(table_q[n]);
      if (u_spi_slave_top.u_spi_cmd_decode.u_spi_slave_properties.fail_count == 0)
      begin
         $display("Testbench passed");
         $finish;
      end
      else
      begin
         $display("Testbench failed");
         $fatal(1, "concurrent assertions failed in the decode FSM");
      end
   end

endmodule

`default_nettype wire

// File: spi_slave.f
hdl/spi_slave_pkg.sv
hdl/spi_pin_sync.sv
hdl/spi_cmd_decode.sv
hdl/spi_regfile.sv
hdl/spi_core_access.sv
hdl/spi_slave_top.sv
testbench/spi_slave_properties.sv
testbench/spi_slave_tb.sv
